// ==== build.f ====
+incdir+sim
src/core_shell_pkg.sv
src/reg_file_ff.sv
src/scramble_key_ctrl.sv
src/dside_credit_tracker.sv
src/core_shell_top.sv
sim/tb_core_shell.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core shell testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module tb_core_shell \
  -o sim_core_shell && ./obj_dir/sim_core_shell > sim.log 2>&1
grep -q "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== sim/core_shell_trace.txt ====
# test kind ra rb wa we wdata kreq kvalid evt(req gnt rvalid we) wake(busy dbg irq nmi) calert exp0 exp1
# kind 0 drive, 1 rdata a/b, 2 sleep, 3 req/valid/key, 4 credits/alerts, 5 alerts; 7 key in, 8 exp key
1 1 03 03 03 1 a5a5a5a5 0 0 0 0 0 00000000 00000000
1 1 03 05 05 1 12345678 0 0 0 0 0 a5a5a5a5 00000000
1 1 05 03 00 1 ffffffff 0 0 0 0 0 12345678 a5a5a5a5
1 1 00 05 1f 1 deadbeef 0 0 0 0 0 00000000 12345678
1 1 1f 00 00 0 00000000 0 0 0 0 0 deadbeef 00000000
1 1 1f 03 00 0 00000000 0 0 0 0 0 deadbeef a5a5a5a5
2 2 00 00 00 0 00000000 0 0 0 0 0 00000001 00000000
2 2 00 00 00 0 00000000 0 0 0 8 0 00000001 00000000
2 2 00 00 00 0 00000000 0 0 0 8 0 00000000 00000000
2 2 00 00 00 0 00000000 0 0 0 0 0 00000000 00000000
2 2 00 00 00 0 00000000 0 0 0 0 0 00000001 00000000
2 2 00 00 00 0 00000000 0 0 0 4 0 00000000 00000000
2 2 00 00 00 0 00000000 0 0 0 2 0 00000000 00000000
2 2 00 00 00 0 00000000 0 0 0 1 0 00000000 00000000
2 2 00 00 00 0 00000000 0 0 0 0 0 00000001 00000000
3 8 3a5c19e7b2046df18c73e0a951b6247dd16e0b937f2ac845
3 3 00 00 00 0 00000000 0 0 0 0 0 00000000 00000001
3 3 00 00 00 0 00000000 1 0 0 0 0 00000000 00000001
3 3 00 00 00 0 00000000 0 0 0 0 0 00000001 00000000
3 3 00 00 00 0 00000000 0 0 0 0 0 00000001 00000000
3 7 0123456789abcdeffedcba98765432100f1e2d3c4b5a6978
3 3 00 00 00 0 00000000 0 1 0 0 0 00000001 00000000
3 8 0123456789abcdeffedcba98765432100f1e2d3c4b5a6978
3 3 00 00 00 0 00000000 0 0 0 0 0 00000000 00000001
3 3 00 00 00 0 00000000 0 0 0 0 0 00000000 00000001
4 4 00 00 00 0 00000000 0 0 0 0 0 00000002 00000000
4 4 00 00 00 0 00000000 0 0 c 0 0 00000002 00000000
4 4 00 00 00 0 00000000 0 0 d 0 0 00000001 00000000
4 4 00 00 00 0 00000000 0 0 0 0 0 00000000 00000000
4 4 00 00 00 0 00000000 0 0 2 0 0 00000000 00000000
4 4 00 00 00 0 00000000 0 0 2 0 0 00000001 00000000
4 4 00 00 00 0 00000000 0 0 0 0 0 00000002 00000000
5 5 00 00 00 0 00000000 0 0 0 0 4 00000000 00000004
5 5 00 00 00 0 00000000 0 0 0 0 2 00000000 00000002
5 5 00 00 00 0 00000000 0 0 0 0 1 00000000 00000001
5 5 00 00 00 0 00000000 0 0 0 0 7 00000000 00000007
5 5 00 00 00 0 00000000 0 0 0 0 0 00000000 00000000
6 4 00 00 00 0 00000000 0 0 c 0 0 00000002 00000000
6 4 00 00 00 0 00000000 0 0 c 0 0 00000001 00000000
6 4 00 00 00 0 00000000 0 0 c 0 0 00000000 00000000
6 4 00 00 00 0 00000000 0 0 0 0 0 00000000 00000001
6 4 00 00 00 0 00000000 0 0 0 0 0 00000000 00000001
6 4 00 00 00 0 00000000 0 0 0 0 0 00000000 00000001

// ==== sim/tb_core_shell_checks.svh ====
//////////////////////////////
// Typed compare tasks and check counters
// for the core shell testbench
//////////////////////////////

`ifndef TB_CORE_SHELL_CHECKS_SVH
`define TB_CORE_SHELL_CHECKS_SVH

int pass_cnt = 0;
int fail_cnt = 0;

task automatic check_word(input string name, input core_shell_pkg::word_t exp_val,
                          input core_shell_pkg::word_t act_val);
  if (act_val === exp_val) begin
    pass_cnt++;
  end else begin
    fail_cnt++;
    $display("mismatch %s: expected %h, actual %h", name, exp_val, act_val);
  end
endtask

task automatic check_key(input string name, input core_shell_pkg::scr_key_t exp_val,
                         input core_shell_pkg::scr_key_t act_val);
  if (act_val === exp_val) begin
    pass_cnt++;
  end else begin
    fail_cnt++;
    $display("mismatch %s: expected %h, actual %h", name, exp_val, act_val);
  end
endtask

task automatic check_alerts(input string name, input core_shell_pkg::alerts_t exp_val,
                            input core_shell_pkg::alerts_t act_val);
  if (act_val === exp_val) begin
    pass_cnt++;
  end else begin
    fail_cnt++;
    $display("mismatch %s: expected %h, actual %h", name, exp_val, act_val);
  end
endtask

task automatic check_bit(input string name, input logic exp_val, input logic act_val);
  if (act_val === exp_val) begin
    pass_cnt++;
  end else begin
    fail_cnt++;
    $display("mismatch %s: expected %h, actual %h", name, exp_val, act_val);
  end
endtask

`endif

// ==== sim/tb_core_shell.sv ====
//////////////////////////////
// Core shell testbench: clock, reset,
// trace reader, stimulus and timeout
//////////////////////////////

`timescale 1ns/1ps

module tb_core_shell;

  localparam string TracePath = "sim/core_shell_trace.txt";

  logic                       clk_i;
  logic                       rst_ni;
  core_shell_pkg::rf_req_t    rf_req_i;
  core_shell_pkg::rf_rsp_t    rf_rsp_o;
  logic                       scr_key_req_i;
  logic                       scr_key_valid_i;
  core_shell_pkg::scr_key_t   scr_key_i;
  logic                       scramble_req_o;
  logic                       scr_key_valid_o;
  core_shell_pkg::scr_key_t   scr_key_o;
  core_shell_pkg::dside_evt_t dside_evt_i;
  logic [1:0]                 data_credits_o;
  core_shell_pkg::wake_t      wake_i;
  core_shell_pkg::alerts_t    core_alerts_i;
  core_shell_pkg::alerts_t    alerts_o;
  logic                       core_sleep_o;

  int cycle_cnt   = 0;
  int cycle_limit = 100000;

  `include "tb_core_shell_checks.svh"

  core_shell_top i_core_shell_top (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rf_req_i       (rf_req_i),
    .rf_rsp_o       (rf_rsp_o),
    .scr_key_req_i  (scr_key_req_i),
    .scr_key_valid_i(scr_key_valid_i),
    .scr_key_i      (scr_key_i),
    .scramble_req_o (scramble_req_o),
    .scr_key_valid_o(scr_key_valid_o),
    .scr_key_o      (scr_key_o),
    .dside_evt_i    (dside_evt_i),
    .data_credits_o (data_credits_o),
    .wake_i         (wake_i),
    .core_alerts_i  (core_alerts_i),
    .alerts_o       (alerts_o),
    .core_sleep_o   (core_sleep_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Closing line and final verdict
  task automatic end_run(input bit timed_out);
    $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (!timed_out && fail_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, trace did not complete", cycle_cnt);
      end_run(1'b1);
    end
  end

  function automatic bit is_data_line(input string s);
    return s.len() > 1 && s.getc(0) != "#";
  endfunction

  //////////////////////////////
  // Trace replay
  //////////////////////////////

  initial begin
    int          fd;
    int          n_lines;
    int          n_fields;
    int          test_id;
    int          kind;
    int          cur_test;
    int          test_base;
    string       line;
    logic [191:0] key_val;
    logic [31:0] f_ra, f_rb, f_wa, f_we, f_wdata;
    logic [31:0] f_kr, f_kv, f_evt, f_wk, f_ca;
    logic [31:0] f_e0, f_e1;
    core_shell_pkg::scr_key_t exp_key;
    core_shell_pkg::scr_key_t key_src;

    rf_req_i        = '0;
    scr_key_req_i   = 1'b0;
    scr_key_valid_i = 1'b0;
    scr_key_i       = '0;
    dside_evt_i     = '0;
    wake_i          = '0;
    core_alerts_i   = '0;
    rst_ni          = 1'b0;
    exp_key         = '0;
    key_src         = '0;
    n_lines         = 0;
    cur_test        = -1;
    test_base       = 0;

    fd = $fopen(TracePath, "r");
    if (fd == 0) begin
      $display("cannot open trace file %s", TracePath);
      fail_cnt++;
    end else begin
      // First pass sizes the timeout
      while ($fgets(line, fd) != 0) begin
        if (is_data_line(line)) n_lines++;
      end
      $fclose(fd);
      cycle_limit = 8 * n_lines + 20;

      repeat (2) @(posedge clk_i);
      #2 rst_ni = 1'b1;

      fd = $fopen(TracePath, "r");
      while ($fgets(line, fd) != 0) begin
        if (is_data_line(line)) begin
          n_fields = $sscanf(line, "%d %d", test_id, kind);
          if (test_id != cur_test) begin
            if (cur_test >= 0) begin
              $display("test %0d done: %0d errors", cur_test, fail_cnt - test_base);
            end
            cur_test  = test_id;
            test_base = fail_cnt;
          end
          if (kind == 7 || kind == 8) begin
            n_fields = $sscanf(line, "%d %d %h", test_id, kind, key_val);
            if (n_fields != 3) begin
              fail_cnt++;
              $display("key line in test %0d is malformed", test_id);
            end else if (kind == 7) begin
              // Key source value, driven with the next step
              key_src = core_shell_pkg::scr_key_t'(key_val);
            end else begin
              exp_key = core_shell_pkg::scr_key_t'(key_val);
            end
          end else begin
            n_fields = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h %h %h %h %h",
                               test_id, kind, f_ra, f_rb, f_wa, f_we, f_wdata,
                               f_kr, f_kv, f_evt, f_wk, f_ca, f_e0, f_e1);
            if (n_fields != 14) begin
              fail_cnt++;
              $display("trace line in test %0d is malformed", test_id);
            end else begin
              @(posedge clk_i);
              #2;
              rf_req_i.raddr_a = f_ra[4:0];
              rf_req_i.raddr_b = f_rb[4:0];
              rf_req_i.waddr   = f_wa[4:0];
              rf_req_i.we      = f_we[0];
              rf_req_i.wdata   = f_wdata;
              scr_key_req_i    = f_kr[0];
              scr_key_valid_i  = f_kv[0];
              scr_key_i        = key_src;
              dside_evt_i      = core_shell_pkg::dside_evt_t'(f_evt[3:0]);
              wake_i           = core_shell_pkg::wake_t'(f_wk[3:0]);
              core_alerts_i    = core_shell_pkg::alerts_t'(f_ca[2:0]);
              // Sample just before the next rising edge
              #36;
              case (kind)
                0: ;
                1: begin
                  check_word("rdata_a", f_e0, rf_rsp_o.rdata_a);
                  check_word("rdata_b", f_e1, rf_rsp_o.rdata_b);
                end
                2: check_bit("core_sleep_o", f_e0[0], core_sleep_o);
                3: begin
                  check_bit("scramble_req_o", f_e0[0], scramble_req_o);
                  check_bit("scr_key_valid_o", f_e1[0], scr_key_valid_o);
                  check_key("scr_key_o", exp_key, scr_key_o);
                end
                4: begin
                  check_word("data_credits_o", f_e0, {30'b0, data_credits_o});
                  check_alerts("alerts_o", core_shell_pkg::alerts_t'(f_e1[2:0]), alerts_o);
                end
                5: check_alerts("alerts_o", core_shell_pkg::alerts_t'(f_e1[2:0]), alerts_o);
                default: begin
                  fail_cnt++;
                  $display("unknown step kind %0d in test %0d", kind, test_id);
                end
              endcase
            end
          end
        end
      end
      $fclose(fd);
      if (cur_test >= 0) begin
        $display("test %0d done: %0d errors", cur_test, fail_cnt - test_base);
      end
    end
    end_run(1'b0);
  end

endmodule

// ==== src/core_shell_pkg.sv ====
//////////////////////////////
// Shared widths, reset constants and packed
// structs of the core shell
//////////////////////////////

package core_shell_pkg;

  // Widths
  localparam int unsigned DataW     = 32;
  localparam int unsigned RegAddrW  = 5;
  localparam int unsigned ScrKeyW   = 128;
  localparam int unsigned ScrNonceW = 64;

  // Default number of data-side credits
  localparam int unsigned MaxOutstanding = 2;

  // Key and nonce loaded at reset
  localparam logic [ScrKeyW-1:0]   ScrKeyRst   = 128'h3a5c_19e7_b204_6df1_8c73_e0a9_51b6_247d;
  localparam logic [ScrNonceW-1:0] ScrNonceRst = 64'hd16e_0b93_7f2a_c845;

  typedef logic [DataW-1:0]    word_t;
  typedef logic [RegAddrW-1:0] reg_addr_t;

  typedef struct packed {
    reg_addr_t raddr_a;
    reg_addr_t raddr_b;
    reg_addr_t waddr;
    logic      we;
    word_t     wdata;
  } rf_req_t;

  typedef struct packed {
    word_t rdata_a;
    word_t rdata_b;
  } rf_rsp_t;

  typedef struct packed {
    logic [ScrKeyW-1:0]   key;
    logic [ScrNonceW-1:0] nonce;
  } scr_key_t;

  // Data bus as observed from the shell
  typedef struct packed {
    logic req;
    logic gnt;
    logic rvalid;
    logic we;
  } dside_evt_t;

  typedef struct packed {
    logic core_busy;
    logic debug_req;
    logic irq_pending;
    logic irq_nm;
  } wake_t;

  typedef struct packed {
    logic minor;
    logic major_internal;
    logic major_bus;
  } alerts_t;

endpackage

// ==== src/core_shell_top.sv ====
//////////////////////////////
// Core shell top level: sleep indication,
// alert combination, register file, scramble
// key handshake and data-side tracker
//////////////////////////////

`timescale 1ns/1ps

module core_shell_top #(
  parameter int unsigned              NumRegs = 32,
  parameter int unsigned              Credits = core_shell_pkg::MaxOutstanding,
  parameter core_shell_pkg::scr_key_t KeyRst  = '{
    key:   core_shell_pkg::ScrKeyRst,
    nonce: core_shell_pkg::ScrNonceRst
  }
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // Register file
  input  core_shell_pkg::rf_req_t    rf_req_i,
  output core_shell_pkg::rf_rsp_t    rf_rsp_o,

  // Scramble key
  input  logic                       scr_key_req_i,
  input  logic                       scr_key_valid_i,
  input  core_shell_pkg::scr_key_t   scr_key_i,
  output logic                       scramble_req_o,
  output logic                       scr_key_valid_o,
  output core_shell_pkg::scr_key_t   scr_key_o,

  // Data bus observation
  input  core_shell_pkg::dside_evt_t dside_evt_i,
  output logic [1:0]                 data_credits_o,

  // Wake sources and alerts
  input  core_shell_pkg::wake_t      wake_i,
  input  core_shell_pkg::alerts_t    core_alerts_i,
  output core_shell_pkg::alerts_t    alerts_o,
  output logic                       core_sleep_o
);

  logic core_busy_q;
  logic core_active;
  logic bus_alert;

  //////////////////////////////
  // Sleep indication
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= wake_i.core_busy;
    end
  end

  // Wake sources other than busy act in the same cycle
  assign core_active  = core_busy_q | wake_i.debug_req | wake_i.irq_pending | wake_i.irq_nm;
  assign core_sleep_o = ~core_active;

  //////////////////////////////
  // Submodules
  //////////////////////////////

  reg_file_ff #(
    .NumRegs(NumRegs)
  ) i_reg_file_ff (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .rf_req_i(rf_req_i),
    .rf_rsp_o(rf_rsp_o)
  );

  scramble_key_ctrl #(
    .KeyRst(KeyRst)
  ) i_scramble_key_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .scr_key_req_i  (scr_key_req_i),
    .scr_key_valid_i(scr_key_valid_i),
    .scr_key_i      (scr_key_i),
    .scramble_req_o (scramble_req_o),
    .scr_key_valid_o(scr_key_valid_o),
    .scr_key_o      (scr_key_o)
  );

  dside_credit_tracker #(
    .Credits(Credits)
  ) i_dside_credit_tracker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .dside_evt_i(dside_evt_i),
    .credits_o  (data_credits_o),
    .bus_alert_o(bus_alert)
  );

  //////////////////////////////
  // Alerts
  //////////////////////////////

  assign alerts_o.minor          = core_alerts_i.minor;
  assign alerts_o.major_internal = core_alerts_i.major_internal;
  // Bus errors from the core or seen by the tracker
  assign alerts_o.major_bus      = core_alerts_i.major_bus | bus_alert;

endmodule

// ==== src/dside_credit_tracker.sv ====
//////////////////////////////
// Data-side credit counter, sticky bus alert
// and queue of pending access kinds
//////////////////////////////

`timescale 1ns/1ps

module dside_credit_tracker #(
  parameter int unsigned Credits = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  core_shell_pkg::dside_evt_t dside_evt_i,
  output logic [1:0]                 credits_o,
  output logic                       bus_alert_o
);

  localparam logic [1:0] CreditsFull = 2'(Credits);

  typedef struct packed {
    logic valid;
    logic is_read;
  } pending_t;

  logic        accept, resp;
  logic        overrun, spurious;
  logic [1:0]  credits_d, credits_q;
  logic        alert_q;
  pending_t    pending_d [Credits];
  pending_t    pending_q [Credits];
  int unsigned pending_cnt;

  assign accept = dside_evt_i.req & dside_evt_i.gnt;
  assign resp   = dside_evt_i.rvalid;

  // Bus protocol errors
  assign overrun  = accept && !resp && (credits_q == '0);
  assign spurious = resp && (credits_q == CreditsFull);

  //////////////////////////////
  // Credit count
  //////////////////////////////

  always_comb begin
    credits_d = credits_q;
    if (accept && !resp && credits_q != '0) begin
      credits_d = credits_q - 2'd1;
    end else if (resp && !accept && credits_q != CreditsFull) begin
      credits_d = credits_q + 2'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credits_q <= CreditsFull;
      alert_q   <= 1'b0;
    end else begin
      credits_q <= credits_d;
      // Sticky until reset
      alert_q   <= alert_q | overrun | spurious;
    end
  end

  assign credits_o   = credits_q;
  assign bus_alert_o = alert_q;

  //////////////////////////////
  // Pending access queue
  //////////////////////////////

  always_comb begin
    logic pushed;
    pushed    = 1'b0;
    pending_d = pending_q;
    // Oldest entry retires on a response
    if (resp) begin
      for (int i = 0; i < Credits - 1; i++) begin
        pending_d[i] = pending_q[i + 1];
      end
      pending_d[Credits - 1] = '0;
    end
    // New access goes to the first free slot
    if (accept) begin
      for (int i = 0; i < Credits; i++) begin
        if (!pushed && !pending_d[i].valid) begin
          pending_d[i] = '{valid: 1'b1, is_read: ~dside_evt_i.we};
          pushed       = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '{default: '0};
    end else begin
      pending_q <= pending_d;
    end
  end

  // Occupied queue slots
  always_comb begin
    pending_cnt = 0;
    for (int i = 0; i < Credits; i++) begin
      pending_cnt += pending_q[i].valid;
    end
  end

  response_pending_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    resp |-> pending_q[0].valid
  ) else $error("data response with no access pending");

  // Free credits plus pending accesses stay within the credit limit
  credits_bounded_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    credits_q + pending_cnt <= Credits
  ) else $error("credit count above the credit limit");

endmodule

// ==== src/reg_file_ff.sv ====
//////////////////////////////
// Flip-flop register file, two read ports,
// one write port, register 0 fixed at zero
//////////////////////////////

`timescale 1ns/1ps

module reg_file_ff #(
  parameter int unsigned NumRegs = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  core_shell_pkg::rf_req_t rf_req_i,
  output core_shell_pkg::rf_rsp_t rf_rsp_o
);

  // Full address space with entries past NumRegs tied to zero
  localparam int unsigned NumWords = 2 ** core_shell_pkg::RegAddrW;

  core_shell_pkg::word_t rf_q [NumWords];
  logic [NumWords-1:0]   we_dec;

  //////////////////////////////
  // Storage
  //////////////////////////////

  for (genvar i = 0; i < NumWords; i++) begin : g_rf
    if (i > 0 && i < NumRegs) begin : g_flop
      core_shell_pkg::word_t reg_q;

      // One-hot decode of the write port
      assign we_dec[i] = rf_req_i.we &&
                         (rf_req_i.waddr == core_shell_pkg::reg_addr_t'(i));

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          reg_q <= '0;
        end else if (we_dec[i]) begin
          reg_q <= rf_req_i.wdata;
        end
      end

      assign rf_q[i] = reg_q;
    end else begin : g_zero
      // x0 and unimplemented registers
      assign we_dec[i] = 1'b0;
      assign rf_q[i]   = '0;
    end
  end

  //////////////////////////////
  // Read ports
  //////////////////////////////

  // Combinational read in the cycle of the address
  assign rf_rsp_o.rdata_a = rf_q[rf_req_i.raddr_a];
  assign rf_rsp_o.rdata_b = rf_q[rf_req_i.raddr_b];

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // A write lands in at most one register
  we_onehot_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0(we_dec)
  ) else $error("register file write enable not one-hot");

endmodule

// ==== src/scramble_key_ctrl.sv ====
//////////////////////////////
// Scramble key request handshake with
// the key and nonce registers
//////////////////////////////

`timescale 1ns/1ps

module scramble_key_ctrl #(
  parameter core_shell_pkg::scr_key_t KeyRst = '0
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     scr_key_req_i,
  input  logic                     scr_key_valid_i,
  input  core_shell_pkg::scr_key_t scr_key_i,
  output logic                     scramble_req_o,
  output logic                     scr_key_valid_o,
  output core_shell_pkg::scr_key_t scr_key_o
);

  logic                     req_d, req_q;
  logic                     key_valid_d, key_valid_q;
  core_shell_pkg::scr_key_t key_q;

  // Request held until the key source answers
  assign req_d = req_q ? ~scr_key_valid_i : scr_key_req_i;

  // Key invalid from the request until the new key arrives
  assign key_valid_d = req_q         ? scr_key_valid_i :
                       scr_key_req_i ? 1'b0            :
                                       key_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      key_valid_q <= 1'b1;
    end else begin
      req_q       <= req_d;
      key_valid_q <= key_valid_d;
    end
  end

  // Loads on any valid key even without a request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q <= KeyRst;
    end else if (scr_key_valid_i) begin
      key_q <= scr_key_i;
    end
  end

  assign scramble_req_o  = req_q;
  assign scr_key_valid_o = key_valid_q;
  assign scr_key_o       = key_q;

  // An unanswered request never leaves a valid key behind
  key_valid_after_req_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (scramble_req_o && !scr_key_valid_i) |=> !scr_key_valid_o
  ) else $error("key valid without a delivered key");

endmodule
